// ==== cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // Major opcodes of the kept subset
    localparam opcodeT opRtype = 6'h00;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;
    localparam opcodeT opBeq   = 6'h04;

    // R-type function codes
    localparam functT fnAdd = 6'h20;
    localparam functT fnSub = 6'h22;
    localparam functT fnAnd = 6'h24;
    localparam functT fnOr  = 6'h25;
    localparam functT fnSlt = 6'h2a;
    localparam functT fnJr  = 6'h08;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    // Execute operand source, code 3 unused
    typedef logic [1:0] fwdSelT;
    localparam fwdSelT fwdRf  = 2'd0;
    localparam fwdSelT fwdMem = 2'd1;
    localparam fwdSelT fwdWb  = 2'd2;

    ////////////////////////////////////////////////////////////
    // Pipeline register contents
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  aluSrcImm;
        logic  branch;
        logic  jr;
        // Destination from rt instead of rd
        logic  destRt;
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        logic   valid;
        ctrlT   ctrl;
        regIdxT rs;
        regIdxT rt;
        regIdxT dest;
        wordT   rsVal;
        wordT   rtVal;
        wordT   imm;
    } idExT;

    typedef struct packed {
        logic   valid;
        ctrlT   ctrl;
        regIdxT dest;
        wordT   aluResult;
        wordT   storeData;
    } exMemT;

    typedef struct packed {
        logic   valid;
        logic   regWrite;
        regIdxT dest;
        wordT   result;
    } memWbT;

endpackage

`default_nettype wire

// ==== alu.sv ====
`default_nettype none

module alu (
    input  cpuPkg::aluOpT op,
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    output cpuPkg::wordT  result
);

    // Signed view for slt
    logic lessThan;

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        unique case (op)
            cpuPkg::aluAdd: begin
                result = a + b;
            end
            cpuPkg::aluSub: begin
                result = a - b;
            end
            cpuPkg::aluAnd: begin
                result = a & b;
            end
            cpuPkg::aluOr: begin
                result = a | b;
            end
            cpuPkg::aluSlt: begin
                // One bit, zero-extended
                result = {31'b0, lessThan};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== regFile.sv ====
`default_nettype none

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  cpuPkg::regIdxT rdAddrA,
    input  cpuPkg::regIdxT rdAddrB,
    input  cpuPkg::regIdxT wrAddr,
    input  logic           wrEn,
    input  cpuPkg::wordT   wrData,
    output cpuPkg::wordT   rdDataA,
    output cpuPkg::wordT   rdDataB
);

    cpuPkg::wordT regs [32];
    // Real write, $0 excluded
    logic writeLive;

    assign writeLive = wrEn && (wrAddr != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeLive) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Write-first so decode sees the retiring value
    always_comb begin
        rdDataA = regs[rdAddrA];
        rdDataB = regs[rdAddrB];
        if (writeLive && (wrAddr == rdAddrA)) begin
            rdDataA = wrData;
        end
        if (writeLive && (wrAddr == rdAddrB)) begin
            rdDataB = wrData;
        end
    end

endmodule

`default_nettype wire

// ==== controlDecoder.sv ====
`default_nettype none

module controlDecoder (
    input  cpuPkg::wordT instr,
    output cpuPkg::ctrlT ctrl
);

    cpuPkg::opcodeT opcode;
    cpuPkg::functT  funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // No-op unless a known encoding matches
        ctrl       = '0;
        ctrl.aluOp = cpuPkg::aluAdd;
        case (opcode)
            cpuPkg::opRtype: begin
                // R-type writes rd
                ctrl.regWrite = 1'b1;
                case (funct)
                    cpuPkg::fnAdd: ctrl.aluOp = cpuPkg::aluAdd;
                    cpuPkg::fnSub: ctrl.aluOp = cpuPkg::aluSub;
                    cpuPkg::fnAnd: ctrl.aluOp = cpuPkg::aluAnd;
                    cpuPkg::fnOr:  ctrl.aluOp = cpuPkg::aluOr;
                    cpuPkg::fnSlt: ctrl.aluOp = cpuPkg::aluSlt;
                    cpuPkg::fnJr: begin
                        ctrl.regWrite = 1'b0;
                        ctrl.jr       = 1'b1;
                    end
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            cpuPkg::opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.destRt    = 1'b1;
            end
            cpuPkg::opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.destRt    = 1'b1;
            end
            cpuPkg::opSw: begin
                // Address from base plus offset
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            cpuPkg::opBeq: begin
                // Compare happens in decode, ALU idle
                ctrl.branch = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hazardDetector.sv ====
`default_nettype none

module hazardDetector (
    input  cpuPkg::regIdxT ifIdRs,
    input  cpuPkg::regIdxT ifIdRt,
    input  logic           isBranch,
    input  logic           isJr,
    input  cpuPkg::regIdxT idExDest,
    input  logic           idExMemRead,
    input  logic           idExRegWrite,
    input  cpuPkg::regIdxT exMemDest,
    input  logic           exMemMemRead,
    input  logic           exMemRegWrite,
    output logic           stall
);

    // Source matches against the execute entry, zero never counts
    logic rsMatchEx;
    logic rtMatchEx;
    // Same against the memory entry
    logic rsMatchMem;
    logic rtMatchMem;
    logic loadUse;
    logic ctrlEx;
    logic ctrlMem;

    assign rsMatchEx  = (ifIdRs != '0) && (ifIdRs == idExDest);
    assign rtMatchEx  = (ifIdRt != '0) && (ifIdRt == idExDest);
    assign rsMatchMem = (ifIdRs != '0) && (ifIdRs == exMemDest);
    assign rtMatchMem = (ifIdRt != '0) && (ifIdRt == exMemDest);

    // Load in execute feeding anything in decode
    assign loadUse = idExMemRead && (rsMatchEx || rtMatchEx);

    // Branch compares in decode, jr reads rs only
    // Any pending write in execute blocks it
    assign ctrlEx = idExRegWrite &&
                    (((isBranch || isJr) && rsMatchEx) || (isBranch && rtMatchEx));

    // ALU results in memory are bypassed, loads are not
    assign ctrlMem = exMemRegWrite && exMemMemRead &&
                     (((isBranch || isJr) && rsMatchMem) || (isBranch && rtMatchMem));

    assign stall = loadUse || ctrlEx || ctrlMem;

    // A load in execute or memory always writes its destination
    loadWritesReg: assert final ((!idExMemRead || idExRegWrite) &&
                                 (!exMemMemRead || exMemRegWrite))
        else $error("load entry seen without a register write");

endmodule

`default_nettype wire

// ==== forwardUnit.sv ====
`default_nettype none

module forwardUnit (
    input  cpuPkg::regIdxT idExRs,
    input  cpuPkg::regIdxT idExRt,
    input  cpuPkg::regIdxT exMemDest,
    input  cpuPkg::regIdxT memWbDest,
    input  logic           exMemRegWrite,
    input  logic           memWbRegWrite,
    output cpuPkg::fwdSelT fwdA,
    output cpuPkg::fwdSelT fwdB
);

    // Youngest producer wins, register file last
    function automatic cpuPkg::fwdSelT pickSource(input cpuPkg::regIdxT src);
        cpuPkg::fwdSelT sel;
        sel = cpuPkg::fwdRf;
        if (src == '0) begin
            // $0 reads as zero from the file
            sel = cpuPkg::fwdRf;
        end else if (exMemRegWrite && (exMemDest == src)) begin
            sel = cpuPkg::fwdMem;
        end else if (memWbRegWrite && (memWbDest == src)) begin
            sel = cpuPkg::fwdWb;
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSource(idExRs);
        fwdB = pickSource(idExRt);
    end

endmodule

`default_nettype wire

// ==== dataMemory.sv ====
`default_nettype none

module dataMemory #(
    parameter int dataWords = 256
) (
    input  logic         clk,
    input  cpuPkg::wordT addr,
    input  cpuPkg::wordT wrData,
    input  logic         wrEn,
    output cpuPkg::wordT rdData
);

    localparam int idxW = $clog2(dataWords);

    // Starts all zero
    cpuPkg::wordT mem [dataWords] = '{default: '0};
    // Word index, upper address bits wrap
    logic [idxW-1:0] wordIdx;

    assign wordIdx = addr[idxW+1:2];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    // Load data same cycle
    assign rdData = mem[wordIdx];

    misalignedStore: assert property (@(posedge clk) wrEn |-> (addr[1:0] == 2'b00))
        else $error("misaligned store to address %h", addr);

endmodule

`default_nettype wire

// ==== pipelineCpu.sv ====
`default_nettype none

module pipelineCpu #(
    parameter int dataWords = 256
) (
    input  logic           clk,
    input  logic           rstN,
    output cpuPkg::wordT   imemAddr,
    input  cpuPkg::wordT   imemData,
    output logic           wbValid,
    output cpuPkg::regIdxT wbReg,
    output cpuPkg::wordT   wbData
);

    typedef struct packed {
        logic         valid;
        cpuPkg::wordT instr;
        cpuPkg::wordT pcPlus4;
    } ifIdT;

    cpuPkg::wordT   pc;
    cpuPkg::wordT   pcPlus4;
    ifIdT           ifId;
    cpuPkg::idExT   idEx;
    cpuPkg::idExT   idExNext;
    cpuPkg::exMemT  exMem;
    cpuPkg::memWbT  memWb;
    cpuPkg::wordT   decInstr;
    cpuPkg::regIdxT decRs;
    cpuPkg::regIdxT decRt;
    cpuPkg::regIdxT decRd;
    cpuPkg::wordT   decImm;
    cpuPkg::ctrlT   decCtrl;
    cpuPkg::wordT   rfA;
    cpuPkg::wordT   rfB;
    cpuPkg::wordT   brA;
    cpuPkg::wordT   brB;
    cpuPkg::wordT   brTarget;
    logic           redirect;
    logic           stall;
    cpuPkg::fwdSelT fwdA;
    cpuPkg::fwdSelT fwdB;
    cpuPkg::wordT   exOpA;
    cpuPkg::wordT   exOpB;
    cpuPkg::wordT   aluResult;
    cpuPkg::wordT   memRdData;
    logic           rfWrEn;

    ////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////

    assign imemAddr = pc;
    assign pcPlus4  = pc + 32'd4;

    // Stall holds PC and IF/ID, redirect squashes the fetched word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc   <= '0;
            ifId <= '0;
        end else if (!stall) begin
            pc           <= redirect ? brTarget : pcPlus4;
            ifId.valid   <= !redirect;
            ifId.instr   <= imemData;
            ifId.pcPlus4 <= pcPlus4;
        end
    end

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    // Empty slot decodes as all-zero word, a no-op
    assign decInstr = ifId.valid ? ifId.instr : '0;
    assign decRs    = decInstr[25:21];
    assign decRt    = decInstr[20:16];
    assign decRd    = decInstr[15:11];
    assign decImm   = {{16{decInstr[15]}}, decInstr[15:0]};

    controlDecoder ctrlDec_i (
        .instr(decInstr),
        .ctrl (decCtrl)
    );

    regFile regFile_i (
        .clk    (clk),
        .rstN   (rstN),
        .rdAddrA(decRs),
        .rdAddrB(decRt),
        .wrAddr (memWb.dest),
        .wrEn   (rfWrEn),
        .wrData (memWb.result),
        .rdDataA(rfA),
        .rdDataB(rfB)
    );

    hazardDetector hazard_i (
        .ifIdRs       (decRs),
        .ifIdRt       (decRt),
        .isBranch     (decCtrl.branch),
        .isJr         (decCtrl.jr),
        .idExDest     (idEx.dest),
        .idExMemRead  (idEx.valid && idEx.ctrl.memRead),
        .idExRegWrite (idEx.valid && idEx.ctrl.regWrite),
        .exMemDest    (exMem.dest),
        .exMemMemRead (exMem.valid && exMem.ctrl.memRead),
        .exMemRegWrite(exMem.valid && exMem.ctrl.regWrite)
        ,.stall       (stall)
    );

    // Branch operands, ALU result in memory bypassed
    always_comb begin
        brA = rfA;
        brB = rfB;
        if (exMem.valid && exMem.ctrl.regWrite && !exMem.ctrl.memRead) begin
            if ((decRs != '0) && (exMem.dest == decRs)) begin
                brA = exMem.aluResult;
            end
            if ((decRt != '0) && (exMem.dest == decRt)) begin
                brB = exMem.aluResult;
            end
        end
    end

    // jr jumps to rs, beq to pc+4 plus word offset
    assign brTarget = decCtrl.jr ? brA : ifId.pcPlus4 + {decImm[29:0], 2'b00};
    assign redirect = !stall && (decCtrl.jr || (decCtrl.branch && (brA == brB)));

    always_comb begin
        idExNext.valid = ifId.valid;
        idExNext.ctrl  = decCtrl;
        idExNext.rs    = decRs;
        idExNext.rt    = decRt;
        idExNext.dest  = decCtrl.destRt ? decRt : decRd;
        idExNext.rsVal = rfA;
        idExNext.rtVal = rfB;
        idExNext.imm   = decImm;
    end

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////

    forwardUnit fwd_i (
        .idExRs       (idEx.rs),
        .idExRt       (idEx.rt),
        .exMemDest    (exMem.dest),
        .memWbDest    (memWb.dest),
        .exMemRegWrite(exMem.valid && exMem.ctrl.regWrite),
        .memWbRegWrite(rfWrEn),
        .fwdA         (fwdA),
        .fwdB         (fwdB)
    );

    function automatic cpuPkg::wordT pickOperand(input cpuPkg::fwdSelT sel,
                                                 input cpuPkg::wordT regVal);
        cpuPkg::wordT val;
        case (sel)
            cpuPkg::fwdMem: val = exMem.aluResult;
            cpuPkg::fwdWb:  val = memWb.result;
            default:        val = regVal;
        endcase
        return val;
    endfunction

    always_comb begin
        exOpA = pickOperand(fwdA, idEx.rsVal);
        exOpB = pickOperand(fwdB, idEx.rtVal);
    end

    alu alu_i (
        .op    (idEx.ctrl.aluOp),
        .a     (exOpA),
        .b     (idEx.ctrl.aluSrcImm ? idEx.imm : exOpB),
        .result(aluResult)
    );

    ////////////////////////////////////////////////////////////
    // Memory and write-back
    ////////////////////////////////////////////////////////////

    dataMemory #(
        .dataWords(dataWords)
    ) dmem_i (
        .clk   (clk),
        .addr  (exMem.aluResult),
        .wrData(exMem.storeData),
        .wrEn  (exMem.valid && exMem.ctrl.memWrite),
        .rdData(memRdData)
    );

    // Bubble into ID/EX on stall
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            idEx  <= '0;
            exMem <= '0;
            memWb <= '0;
        end else begin
            idEx            <= stall ? '0 : idExNext;
            exMem.valid     <= idEx.valid;
            exMem.ctrl      <= idEx.ctrl;
            exMem.dest      <= idEx.dest;
            exMem.aluResult <= aluResult;
            exMem.storeData <= exOpB;
            memWb.valid     <= exMem.valid;
            memWb.regWrite  <= exMem.ctrl.regWrite;
            memWb.dest      <= exMem.dest;
            memWb.result    <= exMem.ctrl.memRead ? memRdData : exMem.aluResult;
        end
    end

    assign rfWrEn  = memWb.valid && memWb.regWrite;
    // Retire pulse, $0 writes stay silent
    assign wbValid = rfWrEn && (memWb.dest != '0);
    assign wbReg   = memWb.dest;
    assign wbData  = memWb.result;

endmodule

`default_nettype wire

// ==== cpuTb.sv ====
`default_nettype none

module cpuTb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int progLen      = 200;
    localparam int romWords     = 256;
    localparam int dataWords    = 256;
    localparam int drainTimeout = 2000;
    localparam int quietCycles  = 20;

    // Highest fetch address, the slot right after the halt loop
    localparam cpuPkg::wordT fetchLimit = 32'(progLen * 4);

    // Generator instruction kinds
    localparam int kAlu   = 0;
    localparam int kAddi  = 1;
    localparam int kLw    = 2;
    localparam int kSw    = 3;
    localparam int kBeq   = 4;
    localparam int kJrSet = 5;
    localparam int kJr    = 6;
    localparam int kHalt  = 7;

    // One expected retirement
    typedef struct packed {
        cpuPkg::regIdxT idx;
        cpuPkg::wordT   data;
    } wbEntryT;

    logic           clk;
    logic           rstN;
    cpuPkg::wordT   imemAddr;
    cpuPkg::wordT   imemData;
    logic           wbValid;
    cpuPkg::regIdxT wbReg;
    cpuPkg::wordT   wbData;

    cpuPkg::wordT   rom [romWords];
    int             kind [progLen];
    cpuPkg::regIdxT srcA [progLen];
    cpuPkg::regIdxT srcB [progLen];

    // Sequential model state
    cpuPkg::wordT   modelRegs [32];
    cpuPkg::wordT   modelMem [dataWords];
    wbEntryT        expectQ [$];

    int errorCount;
    int checkCount;
    int cyclesSinceReset;

    pipelineCpu #(
        .dataWords(dataWords)
    ) dut_i (
        .clk     (clk),
        .rstN    (rstN),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .wbValid (wbValid),
        .wbReg   (wbReg),
        .wbData  (wbData)
    );

    // Instruction ROM, combinational answer
    assign imemData = rom[imemAddr[9:2]];

    always #2 clk = !clk;

    ////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////

    function automatic cpuPkg::wordT encodeR(input cpuPkg::regIdxT rs, input cpuPkg::regIdxT rt,
                                             input cpuPkg::regIdxT rd, input cpuPkg::functT fn);
        return {cpuPkg::opRtype, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic cpuPkg::wordT encodeI(input cpuPkg::opcodeT op, input cpuPkg::regIdxT rs,
                                             input cpuPkg::regIdxT rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Mostly $1..$4, sometimes $0, rarely anything
    function automatic cpuPkg::regIdxT pickReg();
        int r;
        r = $urandom % 16;
        if (r < 2) begin
            return 5'd0;
        end else if (r < 13) begin
            return 5'(1 + (r % 4));
        end
        return 5'($urandom % 32);
    endfunction

    // Aligned word offset inside data memory
    // Mostly a handful of words so that loads meet earlier stores
    function automatic logic [15:0] pickOffset();
        if (($urandom % 4) != 0) begin
            return 16'(($urandom % 8) * 4);
        end
        return 16'(($urandom % dataWords) * 4);
    endfunction

    task automatic buildProgram();
        int idx;
        int sel;
        int target;
        cpuPkg::functT fnTab [5];
        fnTab = '{cpuPkg::fnAdd, cpuPkg::fnSub, cpuPkg::fnAnd, cpuPkg::fnOr, cpuPkg::fnSlt};
        for (int i = 0; i < romWords; i++) begin
            rom[i] = '0;
        end
        idx = 0;
        // First pass, control targets filled in later
        while (idx < progLen - 1) begin
            sel = $urandom % 16;
            srcA[idx] = pickReg();
            srcB[idx] = pickReg();
            if (sel == 15 && idx + 2 < progLen - 1) begin
                // addi sets the jr register right before the jr
                srcA[idx]     = 5'(1 + ($urandom % 4));
                srcA[idx + 1] = srcA[idx];
                kind[idx]     = kJrSet;
                kind[idx + 1] = kJr;
                idx += 2;
            end else begin
                if (sel < 6) begin
                    kind[idx] = kAlu;
                    rom[idx]  = encodeR(srcA[idx], srcB[idx], pickReg(), fnTab[sel % 5]);
                end else if (sel < 9 || sel == 15) begin
                    kind[idx] = kAddi;
                    rom[idx]  = encodeI(cpuPkg::opAddi, srcA[idx], pickReg(), 16'($urandom));
                end else if (sel < 11) begin
                    kind[idx] = kLw;
                    rom[idx]  = encodeI(cpuPkg::opLw, 5'd0, pickReg(), pickOffset());
                end else if (sel < 13) begin
                    // Store data from a hot register
                    kind[idx] = kSw;
                    rom[idx]  = encodeI(cpuPkg::opSw, 5'd0, srcB[idx], pickOffset());
                end else begin
                    kind[idx] = kBeq;
                end
                idx++;
            end
        end
        // Final self loop
        kind[progLen - 1] = kHalt;
        rom[progLen - 1]  = encodeI(cpuPkg::opBeq, 5'd0, 5'd0, 16'hffff);
        // Second pass, forward targets
        for (int i = 0; i < progLen - 1; i++) begin
            if (kind[i] == kBeq || kind[i] == kJr) begin
                target = i + 1 + ($urandom % 4);
                if (target > progLen - 1) begin
                    target = progLen - 1;
                end
                // Never land on a jr whose addi got skipped
                while (kind[target] == kJr) begin
                    target++;
                end
                if (kind[i] == kBeq) begin
                    rom[i] = encodeI(cpuPkg::opBeq, srcA[i], srcB[i], 16'(target - i - 1));
                end else begin
                    rom[i - 1] = encodeI(cpuPkg::opAddi, 5'd0, srcA[i], 16'(target * 4));
                    rom[i]     = encodeR(srcA[i], 5'd0, 5'd0, cpuPkg::fnJr);
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    task automatic writeReg(input cpuPkg::regIdxT idx, input cpuPkg::wordT val);
        wbEntryT entry;
        // $0 stays zero and never retires visibly
        if (idx != '0) begin
            modelRegs[idx] = val;
            entry.idx      = idx;
            entry.data     = val;
            expectQ.push_back(entry);
        end
    endtask

    task automatic runModel();
        int             pc;
        int             nextPc;
        int             steps;
        cpuPkg::wordT   instr;
        cpuPkg::wordT   a;
        cpuPkg::wordT   b;
        cpuPkg::wordT   imm;
        cpuPkg::wordT   wordAddr;
        cpuPkg::regIdxT rt;
        cpuPkg::regIdxT rd;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dataWords; i++) begin
            modelMem[i] = '0;
        end
        pc    = 0;
        steps = 0;
        while (pc != progLen - 1 && steps < 10 * progLen) begin
            instr    = rom[pc];
            rt       = instr[20:16];
            rd       = instr[15:11];
            a        = modelRegs[instr[25:21]];
            b        = modelRegs[rt];
            imm      = {{16{instr[15]}}, instr[15:0]};
            wordAddr = (a + imm) >> 2;
            nextPc   = pc + 1;
            case (instr[31:26])
                cpuPkg::opRtype: begin
                    case (instr[5:0])
                        cpuPkg::fnAdd: writeReg(rd, a + b);
                        cpuPkg::fnSub: writeReg(rd, a - b);
                        cpuPkg::fnAnd: writeReg(rd, a & b);
                        cpuPkg::fnOr:  writeReg(rd, a | b);
                        cpuPkg::fnSlt: writeReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        cpuPkg::fnJr:  nextPc = int'(a >> 2);
                        default:       nextPc = pc + 1;
                    endcase
                end
                cpuPkg::opAddi: writeReg(rt, a + imm);
                cpuPkg::opLw:   writeReg(rt, modelMem[wordAddr % dataWords]);
                cpuPkg::opSw:   modelMem[wordAddr % dataWords] = b;
                cpuPkg::opBeq: begin
                    if (a == b) begin
                        nextPc = pc + 1 + int'($signed(imm));
                    end
                end
                default: nextPc = pc + 1;
            endcase
            pc = nextPc;
            steps++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Checker
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rstN) begin
            cyclesSinceReset = 0;
        end else begin
            cyclesSinceReset++;
        end
    end

    // Outputs come from flops, settled by the falling edge
    always @(negedge clk) begin : checkRetire
        wbEntryT head;
        // Fetch stays word aligned inside the program
        assert ((imemAddr[1:0] == 2'b00) && (imemAddr <= fetchLimit)) else begin
            errorCount++;
            $display("CHECK FAILED imemAddr: got %h expected aligned and at most %h",
                     imemAddr, fetchLimit);
        end
        if (!rstN || cyclesSinceReset < 4) begin
            assert (!wbValid) else begin
                errorCount++;
                $display("Write-back pulse seen during reset or in the first cycles after it");
            end
        end else if (wbValid) begin
            assert (expectQ.size() != 0) else begin
                errorCount++;
                $display("Unexpected write-back to register %0d after the program ended", wbReg);
            end
            if (expectQ.size() != 0) begin
                head = expectQ.pop_front();
                checkCount++;
                assert (wbReg == head.idx) else begin
                    errorCount++;
                    $display("CHECK FAILED wbReg: got %h expected %h", wbReg, head.idx);
                end
                assert (wbData == head.data) else begin
                    errorCount++;
                    $display("CHECK FAILED wbData: got %h expected %h", wbData, head.data);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin : mainFlow
        int seedDummy;
        int waitCycles;
        clk              = 1'b0;
        rstN             = 1'b0;
        errorCount       = 0;
        checkCount       = 0;
        cyclesSinceReset = 0;
        seedDummy        = $urandom(87);
        buildProgram();
        runModel();
        $display("Model expects %0d write-backs", expectQ.size());

        repeat (5) @(posedge clk);
        rstN <= 1'b1;

        // Run until every expected retirement is seen
        waitCycles = 0;
        while (expectQ.size() != 0 && waitCycles < drainTimeout) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expectQ.size() != 0) begin
            errorCount++;
            $display("Timeout after %0d cycles with %0d write-backs still missing",
                     waitCycles, expectQ.size());
        end

        // Idle stretch, a stray write-back shows up here
        waitCycles = 0;
        while (waitCycles < quietCycles) begin
            @(posedge clk);
            waitCycles++;
        end

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
cpuPkg.sv
alu.sv
regFile.sv
controlDecoder.sv
hazardDetector.sv
forwardUnit.sv
dataMemory.sv
pipelineCpu.sv
cpuTb.sv

// ==== Bender.yml ====
package:
  name: pipeline_cpu

sources:
  - cpuPkg.sv
  - alu.sv
  - regFile.sv
  - controlDecoder.sv
  - hazardDetector.sv
  - forwardUnit.sv
  - dataMemory.sv
  - pipelineCpu.sv
  - target: test
    files:
      - cpuTb.sv
